// ==== src/rv_pkg.sv ====
/*
 * Shared widths, enums and structs for the multicycle RV32 core.
 * Every RTL module takes what it needs through a wildcard import.
 */
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes, encoded as in the ISA
  typedef enum logic [6:0] {
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_branch  = 7'b1100011,
    op_jalr    = 7'b1100111,
    op_jal     = 7'b1101111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011,
    op_auipc   = 7'b0010111,
    op_lui     = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_execute,
    st_divide,
    st_writeback,
    st_halted
  } core_state_e;

  typedef struct packed {
    opcode_e  opcode;
    logic [2:0] funct3;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    alu_op_e  alu_op;
    // already sign extended, chosen by format
    word_t    imm;
    logic     use_imm;
    logic     is_div;
    logic     want_remainder;
  } decoded_insn_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
  } dmem_req_t;

endpackage

// ==== src/insn_decoder.sv ====
/*
 * Combinational instruction decoder. Splits the word held in the
 * instruction register into register indexes, a sign-extended immediate
 * of the right format and an ALU operation.
 */
module insn_decoder
  import rv_pkg::*;
(
  input  word_t         insn,
  output decoded_insn_t dec
);

  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec.opcode = opcode_e'(insn[6:0]);
    dec.funct3 = insn[14:12];
    dec.rd     = insn[11:7];
    dec.rs1    = insn[19:15];
    dec.rs2    = insn[24:20];

    case (dec.opcode)
      op_store:         dec.imm = imm_s;
      op_branch:        dec.imm = imm_b;
      op_jal:           dec.imm = imm_j;
      op_lui, op_auipc: dec.imm = imm_u;
      default:          dec.imm = imm_i;
    endcase

    dec.use_imm = (dec.opcode == op_load) || (dec.opcode == op_store) ||
                  (dec.opcode == op_jalr) || (dec.opcode == op_reg_imm);

    // only divu (101) and remu (111) of the M group are kept
    dec.is_div = (dec.opcode == op_reg_reg) && (funct7 == 7'b0000001) &&
                 (dec.funct3[2] && dec.funct3[0]);
    dec.want_remainder = dec.funct3[1];

    // address arithmetic for loads, stores and jalr is a plain add
    dec.alu_op = alu_add;
    if ((dec.opcode == op_reg_reg) || (dec.opcode == op_reg_imm)) begin
      case (dec.funct3)
        3'b000: begin
          // sub only exists in register form
          if ((dec.opcode == op_reg_reg) && funct7[5]) begin
            dec.alu_op = alu_sub;
          end else begin
            dec.alu_op = alu_add;
          end
        end
        3'b001:  dec.alu_op = alu_sll;
        3'b010:  dec.alu_op = alu_slt;
        3'b011:  dec.alu_op = alu_sltu;
        3'b100:  dec.alu_op = alu_xor;
        3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
        3'b110:  dec.alu_op = alu_or;
        default: dec.alu_op = alu_and;
      endcase
    end
  end

endmodule

// ==== src/reg_file.sv ====
/*
 * Integer register file with two read ports and one write port.
 * x0 is not stored and always reads as zero.
 */
module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  reg_idx_t rd,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // asynchronous reads
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/alu.sv ====
/*
 * Arithmetic and logic unit plus the branch comparator.
 * The comparator always looks at a and b and uses funct3 to pick the test.
 */
module alu
  import rv_pkg::*;
(
  input  alu_op_e    op,
  input  logic [2:0] funct3,
  input  word_t      a,
  input  word_t      b,
  output word_t      result,
  output logic       branch_taken
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = word_t'(lt_signed);
      alu_sltu: result = word_t'(lt_unsigned);
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = (a == b);
      3'b001:  branch_taken = (a != b);
      3'b100:  branch_taken = lt_signed;
      3'b101:  branch_taken = !lt_signed;
      3'b110:  branch_taken = lt_unsigned;
      3'b111:  branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== src/serial_divider.sv ====
/*
 * Unsigned restoring divider, one quotient bit per step.
 * Load with start, then give XLEN steps; result holds the quotient or the
 * remainder depending on want_remainder sampled at start.
 */
module serial_divider
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  start,
  input  logic  step,
  input  word_t dividend,
  input  word_t divisor,
  input  logic  want_remainder,
  output word_t result
);

  word_t           rem_q;
  word_t           quo_q;
  word_t           divisor_q;
  logic            want_rem_q;
  logic [XLEN:0]   partial;
  logic [XLEN:0]   diff;

  // quotient register doubles as the dividend shifter
  assign partial = {rem_q, quo_q[XLEN-1]};
  assign diff    = partial - {1'b0, divisor_q};

  always_ff @(posedge clk) begin
    if (start) begin
      rem_q      <= '0;
      quo_q      <= dividend;
      divisor_q  <= divisor;
      want_rem_q <= want_remainder;
    end else if (step) begin
      if (!diff[XLEN]) begin
        // divisor fits, keep the difference
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= partial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // divide by zero falls out naturally: all ones and the dividend
  assign result = want_rem_q ? rem_q : quo_q;

endmodule

// ==== src/div_step_counter.sv ====
/*
 * Counts divider steps from start and flags the XLEN-th one so the
 * sequencer knows when the divider is done.
 */
module div_step_counter
  import rv_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic step,
  output logic last
);

  localparam int COUNT_W = $clog2(XLEN);

  logic [COUNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst || start) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  assign last = step && (count == COUNT_W'(XLEN - 1));

endmodule

// ==== src/core_fsm.sv ====
/*
 * Sequencer of the core: holds state, PC and instruction register.
 * Fetch latches the word, execute does all updates for normal instructions,
 * divides wait in st_divide and write back one cycle later.
 */
module core_fsm
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  word_t         imem_data,
  output word_t         insn,
  input  decoded_insn_t dec,
  input  word_t         rs1_data,
  input  word_t         rs2_data,
  input  word_t         alu_result,
  input  logic          branch_taken,
  input  word_t         div_result,
  input  logic          div_last,
  input  word_t         dmem_rdata,
  output word_t         op_b,
  output logic          rd_we,
  output word_t         rd_data,
  output logic          div_start,
  output logic          div_step,
  output word_t         imem_addr,
  output dmem_req_t     dmem_req,
  output logic          halt
);

  core_state_e state;
  core_state_e next_state;
  word_t       pc;
  word_t       next_pc;
  word_t       pc_plus4;
  word_t       pc_imm;
  word_t       jalr_target;
  logic        is_ecall;

  assign pc_plus4    = pc + 32'd4;
  assign pc_imm      = pc + dec.imm;
  assign jalr_target = (rs1_data + dec.imm) & ~word_t'(1);
  assign is_ecall    = (dec.opcode == op_system) && (dec.funct3 == 3'b000) &&
                       (dec.imm == '0);

  assign op_b      = dec.use_imm ? dec.imm : rs2_data;
  assign imem_addr = pc;
  assign halt      = (state == st_halted);

  assign dmem_req.addr  = {alu_result[XLEN-1:2], 2'b00};
  assign dmem_req.wdata = rs2_data;
  assign dmem_req.we    = (state == st_execute) && (dec.opcode == op_store);

  always_comb begin
    next_state = state;
    next_pc    = pc;
    rd_we      = 1'b0;
    rd_data    = alu_result;
    div_start  = 1'b0;
    div_step   = 1'b0;

    case (state)
      st_fetch: next_state = st_execute;
      st_execute: begin
        next_state = st_fetch;
        next_pc    = pc_plus4;
        case (dec.opcode)
          op_lui: begin
            rd_we   = 1'b1;
            rd_data = dec.imm;
          end
          op_auipc: begin
            rd_we   = 1'b1;
            rd_data = pc_imm;
          end
          op_jal: begin
            rd_we   = 1'b1;
            rd_data = pc_plus4;
            next_pc = pc_imm;
          end
          op_jalr: begin
            rd_we   = 1'b1;
            rd_data = pc_plus4;
            next_pc = jalr_target;
          end
          op_branch: next_pc = branch_taken ? pc_imm : pc_plus4;
          op_load: begin
            rd_we   = 1'b1;
            rd_data = dmem_rdata;
          end
          op_reg_imm: rd_we = 1'b1;
          op_reg_reg: begin
            if (dec.is_div) begin
              // pc held until writeback
              div_start  = 1'b1;
              next_state = st_divide;
              next_pc    = pc;
            end else begin
              rd_we = 1'b1;
            end
          end
          op_system: begin
            if (is_ecall) begin
              next_state = st_halted;
              next_pc    = pc;
            end
          end
          // stores only need the strobe; unknown words just advance
          default: ;
        endcase
      end
      st_divide: begin
        div_step = 1'b1;
        if (div_last) begin
          next_state = st_writeback;
        end
      end
      st_writeback: begin
        rd_we      = 1'b1;
        rd_data    = div_result;
        next_pc    = pc_plus4;
        next_state = st_fetch;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
      pc    <= RESET_PC;
    end else begin
      state <= next_state;
      pc    <= next_pc;
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == st_fetch) begin
      insn <= imem_data;
    end
  end

endmodule

// ==== src/rv_core.sv ====
/*
 * Top level of the multicycle RV32 core. Connects the sequencer, decoder,
 * register file, ALU and divider to the instruction and data ports.
 * Both ports are expected to answer combinationally within the cycle.
 */
module rv_core
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic      clk,
  input  logic      rst,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  output logic      halt
);

  word_t         insn;
  decoded_insn_t dec;
  word_t         rs1_data;
  word_t         rs2_data;
  word_t         op_b;
  word_t         alu_result;
  logic          branch_taken;
  logic          rd_we;
  word_t         rd_data;
  logic          div_start;
  logic          div_step;
  logic          div_last;
  word_t         div_result;

  core_fsm #(
    .RESET_PC (RESET_PC)
  ) i_core_fsm (
    .clk          (clk),
    .rst          (rst),
    .imem_data    (imem_data),
    .insn         (insn),
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .div_result   (div_result),
    .div_last     (div_last),
    .dmem_rdata   (dmem_rdata),
    .op_b         (op_b),
    .rd_we        (rd_we),
    .rd_data      (rd_data),
    .div_start    (div_start),
    .div_step     (div_step),
    .imem_addr    (imem_addr),
    .dmem_req     (dmem_req),
    .halt         (halt)
  );

  insn_decoder i_insn_decoder (
    .insn (insn),
    .dec  (dec)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (rd_we),
    .rd       (dec.rd),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu i_alu (
    .op           (dec.alu_op),
    .funct3       (dec.funct3),
    .a            (rs1_data),
    .b            (op_b),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  serial_divider i_serial_divider (
    .clk            (clk),
    .start          (div_start),
    .step           (div_step),
    .dividend       (rs1_data),
    .divisor        (rs2_data),
    .want_remainder (dec.want_remainder),
    .result         (div_result)
  );

  div_step_counter i_div_step_counter (
    .clk   (clk),
    .rst   (rst),
    .start (div_start),
    .step  (div_step),
    .last  (div_last)
  );

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * Free-running testbench clock, starts low.
 */
module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

// ==== testbench/tb_rv_core.sv ====
/*
 * Testbench for the multicycle RV32 core. Each table entry becomes a short
 * program in the instruction memory; the core runs it to ecall and the word
 * it stores is compared with a value computed from the ISA rules.
 */
module tb_rv_core
  import rv_pkg::*;
();

  localparam int         CLK_PERIOD   = 100;
  localparam int         RESET_CYCLES = 4;
  localparam int         HOLD_CYCLES  = 10;
  localparam word_t      RESET_PC     = '0;
  localparam logic [11:0] STORE_OFS   = 12'h040;
  localparam logic [11:0] SCRATCH_OFS = 12'h020;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_REG   = 7'b0110011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam word_t      ECALL     = 32'h0000_0073;

  typedef enum logic [3:0] {
    k_reg, k_imm, k_x0, k_lui, k_auipc, k_branch, k_jal, k_jalr, k_ldst, k_div
  } case_kind_e;

  typedef struct packed {
    case_kind_e kind;
    logic [2:0] funct3;
    logic       alt;
    word_t      a;
    word_t      b;
    word_t      expected;
    logic [7:0] cycles;
  } test_case_t;

  logic      clk;
  logic      rst;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      halt;

  word_t      imem [0:63];
  word_t      dmem [0:63];
  test_case_t cases [$];
  int         seed = 8578;
  word_t      last_store_addr;
  word_t      last_store_data;
  longint     watchdog_cycles = 100;
  logic       table_ready = 1'b0;

  tb_clock #(.PERIOD(CLK_PERIOD)) i_clock (.clk(clk));

  rv_core #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, word_t got, word_t expected);
    if (got !== expected) begin
      abort_run($sformatf("Mismatch at %0t: %s is 0x%h, expected 0x%h",
                          $time, name, got, expected));
    end
  endtask

  // small assembler
  function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                  logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // reference model of the ISA rules
  function automatic logic signed_lt(word_t a, word_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : '0;
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return {31'b0, signed_lt(a, b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return (a >> sh) | (alt ? fill : '0);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return signed_lt(a, b);
      3'd5:    return !signed_lt(a, b);
      3'd6:    return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic add_case(case_kind_e kind, logic [2:0] f3, logic alt, word_t a, word_t b);
    test_case_t tc;
    logic       taken;
    tc = '{kind: kind, funct3: f3, alt: alt, a: a, b: b, expected: '0, cycles: 8'd14};
    case (kind)
      k_reg:   tc.expected = ref_alu(f3, alt, a, b);
      k_imm:   tc.expected = ref_alu(f3, alt, a, {{20{b[11]}}, b[11:0]});
      k_x0:    tc.expected = '0;
      k_lui:   tc.expected = {b[31:12], 12'h000};
      k_auipc: tc.expected = 32'd16 + {b[31:12], 12'h000};
      k_branch: begin
        taken       = ref_branch(f3, a, b);
        tc.expected = taken ? 32'd2 : 32'd1;
        tc.cycles   = taken ? 8'd16 : 8'd18;
      end
      k_jal, k_jalr: tc.expected = 32'd20;
      k_ldst: begin
        tc.expected = a;
        tc.cycles   = 8'd16;
      end
      default: begin
        // six plain instructions plus one divide
        if (f3 == 3'd5) begin
          tc.expected = (b == '0) ? '1 : a / b;
        end else begin
          tc.expected = (b == '0) ? a : a % b;
        end
        tc.cycles = 8'(12 + XLEN + 3);
      end
    endcase
    cases.push_back(tc);
    watchdog_cycles += tc.cycles + RESET_CYCLES + HOLD_CYCLES + 4;
  endtask

  task automatic build_table();
    word_t      br_a [3] = '{32'd7, 32'hffff_fff0, 32'd16};
    word_t      br_b [3] = '{32'd7, 32'd16, 32'hffff_fff0};
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int f = 0; f < 8; f++) begin
      add_case(k_reg, 3'(f), 1'b0, $random(seed), $random(seed));
      add_case(k_imm, 3'(f), 1'b0, $random(seed), $random(seed));
    end
    add_case(k_reg, 3'd0, 1'b1, $random(seed), $random(seed));
    add_case(k_reg, 3'd5, 1'b1, 32'h8000_1234, 32'd7);
    add_case(k_imm, 3'd5, 1'b1, 32'hf000_0000, 32'd13);
    add_case(k_reg, 3'd2, 1'b0, 32'hffff_fffb, 32'd3);
    add_case(k_reg, 3'd3, 1'b0, 32'd3, 32'hffff_fffb);
    add_case(k_x0, 3'd0, 1'b0, $random(seed), $random(seed));
    add_case(k_lui, 3'd0, 1'b0, '0, $random(seed));
    add_case(k_auipc, 3'd0, 1'b0, '0, $random(seed));
    foreach (br_f3[f]) begin
      foreach (br_a[p]) begin
        add_case(k_branch, br_f3[f], 1'b0, br_a[p], br_b[p]);
      end
    end
    add_case(k_jal, 3'd0, 1'b0, '0, '0);
    // jalr base 24 plus offset 1 lands on word 6 once bit 0 is cleared
    add_case(k_jalr, 3'd0, 1'b0, 32'd24, '0);
    add_case(k_ldst, 3'd2, 1'b0, $random(seed), '0);
    for (int i = 0; i < 3; i++) begin
      add_case(k_div, 3'd5, 1'b0, $random(seed), $random(seed));
      add_case(k_div, 3'd7, 1'b0, $random(seed), $random(seed));
    end
    add_case(k_div, 3'd5, 1'b0, $random(seed), 32'd97);
    add_case(k_div, 3'd7, 1'b0, $random(seed), 32'd97);
    add_case(k_div, 3'd5, 1'b0, $random(seed), '0);
    add_case(k_div, 3'd7, 1'b0, $random(seed), '0);
  endtask

  task automatic load_program(test_case_t tc);
    word_t      hi_a;
    word_t      hi_b;
    int         p;
    logic [4:0] src;
    logic [11:0] imm;
    for (int i = 0; i < 64; i++) begin
      // nops that carry their own address
      imem[i] = enc_i(12'(i * 4), 5'd0, 3'd0, 5'd0, OPC_IMM);
      dmem[i] = 32'h5a5a_0000 ^ word_t'(i * 4);
    end
    hi_a = tc.a + 32'h800;
    hi_b = tc.b + 32'h800;
    imem[0] = enc_u(hi_a[31:12], 5'd1, OPC_LUI);
    imem[1] = enc_i(tc.a[11:0], 5'd1, 3'd0, 5'd1, OPC_IMM);
    imem[2] = enc_u(hi_b[31:12], 5'd2, OPC_LUI);
    imem[3] = enc_i(tc.b[11:0], 5'd2, 3'd0, 5'd2, OPC_IMM);
    p   = 5;
    src = 5'd3;
    case (tc.kind)
      k_reg:   imem[4] = enc_r(tc.alt ? 7'h20 : 7'h00, 5'd2, 5'd1, tc.funct3, 5'd3);
      k_div:   imem[4] = enc_r(7'h01, 5'd2, 5'd1, tc.funct3, 5'd3);
      k_imm: begin
        imm = tc.b[11:0];
        if (tc.funct3 == 3'd1 || tc.funct3 == 3'd5) begin
          imm = {tc.alt ? 7'h20 : 7'h00, tc.b[4:0]};
        end
        imem[4] = enc_i(imm, 5'd1, tc.funct3, 5'd3, OPC_IMM);
      end
      k_x0: begin
        imem[4] = enc_i(tc.b[11:0], 5'd1, 3'd0, 5'd0, OPC_IMM);
        src     = 5'd0;
      end
      k_lui:   imem[4] = enc_u(tc.b[31:12], 5'd3, OPC_LUI);
      k_auipc: imem[4] = enc_u(tc.b[31:12], 5'd3, OPC_AUIPC);
      k_branch: begin
        // the fall-through path stores marker 1 and the taken path marker 2
        imem[4] = enc_b(13'd12, 5'd2, 5'd1, tc.funct3);
        imem[5] = enc_i(12'd1, 5'd0, 3'd0, 5'd3, OPC_IMM);
        imem[6] = enc_j(21'd8, 5'd0);
        imem[7] = enc_i(12'd2, 5'd0, 3'd0, 5'd3, OPC_IMM);
        p       = 8;
      end
      k_jal, k_jalr: begin
        imem[4] = (tc.kind == k_jal) ? enc_j(21'd8, 5'd3) :
                                       enc_i(12'd1, 5'd1, 3'd0, 5'd3, OPC_JALR);
        // overwrites the link if the jump falls through
        imem[5] = enc_i(12'h7ff, 5'd0, 3'd0, 5'd3, OPC_IMM);
        p       = 6;
      end
      default: begin
        imem[4] = enc_s(SCRATCH_OFS, 5'd1, 5'd0);
        imem[5] = enc_i(SCRATCH_OFS, 5'd0, 3'b010, 5'd3, OPC_LOAD);
        p       = 6;
      end
    endcase
    imem[p]     = enc_s(STORE_OFS, src, 5'd0);
    imem[p + 1] = ECALL;
    last_store_addr = '1;
    last_store_data = ~tc.expected;
  endtask

  task automatic run_case(test_case_t tc, int idx);
    int    cycles;
    word_t held_pc;
    @(negedge clk);
    rst = 1'b1;
    load_program(tc);
    repeat (RESET_CYCLES) @(negedge clk);
    check_value("halt in reset", halt, 1'b0);
    check_value("dmem_req.we in reset", dmem_req.we, 1'b0);
    check_value("imem_addr in reset", imem_addr, RESET_PC);
    rst    = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (!halt && cycles > tc.cycles + 4) begin
        abort_run($sformatf("case %0d: core did not halt after %0d cycles", idx, cycles));
      end
    end while (!halt);
    check_value($sformatf("case %0d halt cycle", idx), cycles, tc.cycles);
    check_value($sformatf("case %0d store address", idx), last_store_addr,
                word_t'(STORE_OFS));
    check_value($sformatf("case %0d store data", idx), last_store_data, tc.expected);
    held_pc = imem_addr;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("halt after ecall", halt, 1'b1);
      check_value("imem_addr after ecall", imem_addr, held_pc);
      check_value("dmem_req.we after ecall", dmem_req.we, 1'b0);
    end
  endtask

  // memory models answer on the falling edge
  always @(negedge clk) begin
    check_value("imem_addr[1:0]", imem_addr[1:0], '0);
    check_value("dmem_req.addr[1:0]", dmem_req.addr[1:0], '0);
    if (dmem_req.we === 1'b1) begin
      dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
      last_store_addr          = dmem_req.addr;
      last_store_data          = dmem_req.wdata;
    end
    imem_data  = imem[imem_addr[7:2]];
    dmem_rdata = dmem[dmem_req.addr[7:2]];
  end

  initial begin
    wait (table_ready);
    #(watchdog_cycles * CLK_PERIOD);
    abort_run("watchdog expired, the core never halted");
  end

  initial begin
    rst        = 1'b1;
    imem_data  = '0;
    dmem_rdata = '0;
    build_table();
    table_ready = 1'b1;
    foreach (cases[i]) begin
      run_case(cases[i], i);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== rv_core.f ====
src/rv_pkg.sv
src/insn_decoder.sv
src/reg_file.sv
src/alu.sv
src/serial_divider.sv
src/div_step_counter.sv
src/core_fsm.sv
src/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/insn_decoder.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/serial_divider.sv
  - src/div_step_counter.sv
  - src/core_fsm.sv
  - src/rv_core.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/tb_rv_core.sv
